//--- logic/globefish_pkg.sv
package globefish_pkg;

  // bus payload types
  typedef logic [31:0] adr_t;
  typedef logic [31:0] dat_t;
  typedef logic [3:0]  sel_t;

  // core slots
  localparam int NUM_CORES = 4;
  typedef logic [$clog2(NUM_CORES)-1:0] core_idx_t;

  // word RAM
  localparam int RAM_DEPTH = 256;
  typedef logic [$clog2(RAM_DEPTH)-1:0] ram_idx_t;

  // address map, region is adr[31:28]
  localparam logic [3:0] RAM_REGION = 4'h2;
  localparam logic [3:0] CSR_REGION = 4'h4;

  // csr word offsets on adr[3:2]
  localparam logic [1:0] CSR_GPO_OFS  = 2'd0;
  localparam logic [1:0] CSR_GPOE_OFS = 2'd1;
  localparam logic [1:0] CSR_GPI_OFS  = 2'd2;

  localparam int GPIO_WIDTH = 8;

  // core reset release after bus reset
  localparam int CORE_RST_DELAY = 16;
  typedef logic [$clog2(CORE_RST_DELAY)-1:0] rst_cnt_t;

endpackage

//--- logic/core_port.sv
module core_port (
  input  logic                clk_i,
  input  logic                rst_sync_n,
  // instruction port
  input  logic                imem_cyc_i,
  input  logic                imem_stb_i,
  input  globefish_pkg::adr_t imem_adr_i,
  output logic                imem_ack_o,
  // data port
  input  logic                dmem_cyc_i,
  input  logic                dmem_stb_i,
  input  logic                dmem_we_i,
  input  globefish_pkg::sel_t dmem_be_i,
  input  globefish_pkg::adr_t dmem_adr_i,
  input  globefish_pkg::dat_t dmem_wdat_i,
  output logic                dmem_ack_o,
  // shared read data
  output globefish_pkg::dat_t rdat_o,
  // merged master
  output logic                cyc_o,
  output logic                stb_o,
  output logic                we_o,
  output globefish_pkg::sel_t sel_o,
  output globefish_pkg::adr_t adr_o,
  output globefish_pkg::dat_t wdat_o,
  input  logic                ack_i,
  input  globefish_pkg::dat_t rdat_i
);

  assign cyc_o  = imem_cyc_i | dmem_cyc_i;
  assign stb_o  = imem_stb_i | dmem_stb_i;
  // fetch owns the address while strobing
  assign adr_o  = imem_stb_i ? imem_adr_i : dmem_adr_i;
  assign sel_o  = imem_stb_i ? 4'b1111 : dmem_be_i;
  assign we_o   = dmem_stb_i & dmem_we_i;
  assign wdat_o = dmem_wdat_i;

  // ack back to the strobing side
  assign imem_ack_o = ack_i & imem_stb_i;
  assign dmem_ack_o = ack_i & dmem_stb_i;
  assign rdat_o     = rdat_i;

  // ######################################
  // checks

  a_one_port: assert property (@(posedge clk_i) disable iff (!rst_sync_n)
    !(imem_stb_i && dmem_stb_i));

  // request held while waiting on the interconnect
  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_sync_n)
    (stb_o && !ack_i) |=> (stb_o && $stable(adr_o) && $stable(sel_o) && $stable(we_o)));

endmodule

//--- logic/core_run_ctrl.sv
module core_run_ctrl (
  input  logic                               clk_i,
  input  logic                               rst_sync_n,
  input  logic [globefish_pkg::NUM_CORES-1:0] core_en_i,
  input  logic [globefish_pkg::NUM_CORES-1:0] core_stb_i,
  output logic [globefish_pkg::NUM_CORES-1:0] core_clk_en_o,
  output logic                               core_rst_n_o
);

  globefish_pkg::rst_cnt_t rst_cnt_q;

  // hold cores in reset after the bus comes up
  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      rst_cnt_q    <= '0;
      core_rst_n_o <= 1'b0;
    end else if (rst_cnt_q != globefish_pkg::rst_cnt_t'(globefish_pkg::CORE_RST_DELAY - 1)) begin
      rst_cnt_q <= rst_cnt_q + 1'b1;
    end else begin
      core_rst_n_o <= 1'b1;
    end
  end

  // enable drops only once the core has no strobe out
  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      core_clk_en_o <= '1;
    end else begin
      core_clk_en_o <= core_en_i | (core_clk_en_o & core_stb_i);
    end
  end

  // ######################################
  // checks

  // a stopped core must not hold a strobe on the bus
  for (genvar c = 0; c < globefish_pkg::NUM_CORES; c++) begin : g_chk
    a_stopped_core_idle: assert property (@(posedge clk_i) disable iff (!rst_sync_n)
      !core_clk_en_o[c] |-> !core_stb_i[c]);
  end

endmodule

//--- logic/wb_intercon.sv
module wb_intercon (
  input  logic                                                 clk_i,
  input  logic                                                 rst_sync_n,
  // masters
  input  logic                [globefish_pkg::NUM_CORES-1:0] m_cyc_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] m_stb_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] m_we_i,
  input  globefish_pkg::sel_t [globefish_pkg::NUM_CORES-1:0] m_sel_i,
  input  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] m_adr_i,
  input  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] m_wdat_i,
  output logic                [globefish_pkg::NUM_CORES-1:0] m_ack_o,
  output globefish_pkg::dat_t                                m_rdat_o,
  // shared slave bus
  output logic                                               s_cyc_o,
  output logic                                               s_we_o,
  output globefish_pkg::sel_t                                s_sel_o,
  output globefish_pkg::adr_t                                s_adr_o,
  output globefish_pkg::dat_t                                s_wdat_o,
  output logic                                               s_ram_stb_o,
  input  logic                                               s_ram_ack_i,
  input  globefish_pkg::dat_t                                s_ram_rdat_i,
  output logic                                               s_csr_stb_o,
  input  logic                                               s_csr_ack_i,
  input  globefish_pkg::dat_t                                s_csr_rdat_i
);

  globefish_pkg::core_idx_t gnt_idx_q;
  globefish_pkg::core_idx_t nxt_idx;
  logic                     gnt_vld_q;
  logic                     nxt_found;
  logic                     bus_stb;
  logic                     slv_ack;
  logic                     dflt_ack_q;
  logic [3:0]               region;
  logic                     is_ram;
  logic                     is_csr;

  // ######################################
  // round-robin arbiter

  // search starts after the last winner
  always_comb begin
    globefish_pkg::core_idx_t cand;
    nxt_found = 1'b0;
    nxt_idx   = gnt_idx_q;
    for (int k = 1; k <= globefish_pkg::NUM_CORES; k++) begin
      cand = gnt_idx_q + globefish_pkg::core_idx_t'(k);
      if (!nxt_found && m_cyc_i[cand]) begin
        nxt_found = 1'b1;
        nxt_idx   = cand;
      end
    end
  end

  // grant holds for the whole cycle of the winner
  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      gnt_idx_q <= globefish_pkg::core_idx_t'(globefish_pkg::NUM_CORES - 1);
      gnt_vld_q <= 1'b0;
    end else if (!gnt_vld_q || !m_cyc_i[gnt_idx_q]) begin
      gnt_vld_q <= nxt_found;
      if (nxt_found) begin
        gnt_idx_q <= nxt_idx;
      end
    end
  end

  assign s_cyc_o  = gnt_vld_q & m_cyc_i[gnt_idx_q];
  assign bus_stb  = s_cyc_o & m_stb_i[gnt_idx_q];
  assign s_we_o   = m_we_i[gnt_idx_q];
  assign s_sel_o  = m_sel_i[gnt_idx_q];
  assign s_adr_o  = m_adr_i[gnt_idx_q];
  assign s_wdat_o = m_wdat_i[gnt_idx_q];

  // ######################################
  // address decode

  assign region      = s_adr_o[31:28];
  assign is_ram      = (region == globefish_pkg::RAM_REGION);
  assign is_csr      = (region == globefish_pkg::CSR_REGION);
  assign s_ram_stb_o = bus_stb & is_ram;
  assign s_csr_stb_o = bus_stb & is_csr;

  // unmapped accesses end here with zero data
  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      dflt_ack_q <= 1'b0;
    end else begin
      dflt_ack_q <= bus_stb & ~is_ram & ~is_csr & ~dflt_ack_q;
    end
  end

  assign slv_ack  = s_ram_ack_i | s_csr_ack_i | dflt_ack_q;
  assign m_rdat_o = is_ram ? s_ram_rdat_i : (is_csr ? s_csr_rdat_i : '0);

  always_comb begin
    m_ack_o            = '0;
    m_ack_o[gnt_idx_q] = gnt_vld_q & slv_ack;
  end

  // ######################################
  // checks

  // only one slave answers at a time
  a_slv_ack_onehot: assert property (@(posedge clk_i) disable iff (!rst_sync_n)
    $onehot0({s_ram_ack_i, s_csr_ack_i, dflt_ack_q}));

  // a slave answer must land on a master that is still strobing
  a_ack_to_owner: assert property (@(posedge clk_i) disable iff (!rst_sync_n)
    (m_ack_o != '0) |-> ((m_ack_o & m_stb_i) == m_ack_o));

endmodule

//--- logic/wb_ram.sv
module wb_ram (
  input  logic                clk_i,
  input  logic                rst_sync_n,
  input  logic                cyc_i,
  input  logic                stb_i,
  input  logic                we_i,
  input  globefish_pkg::sel_t sel_i,
  input  globefish_pkg::adr_t adr_i,
  input  globefish_pkg::dat_t wdat_i,
  output logic                ack_o,
  output globefish_pkg::dat_t rdat_o
);

  globefish_pkg::dat_t      mem [globefish_pkg::RAM_DEPTH];
  globefish_pkg::ram_idx_t  word_idx;
  logic                     access;

  // word address wraps within the depth
  assign word_idx = adr_i[$bits(globefish_pkg::ram_idx_t)+1:2];
  assign access   = cyc_i & stb_i & ~ack_o;

  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      rdat_o <= mem[word_idx];
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) begin
            mem[word_idx][8*b +: 8] <= wdat_i[8*b +: 8];
          end
        end
      end
    end
  end

endmodule

//--- logic/csr_gpio.sv
module csr_gpio (
  input  logic                                 clk_i,
  input  logic                                 rst_sync_n,
  input  logic                                 cyc_i,
  input  logic                                 stb_i,
  input  logic                                 we_i,
  input  globefish_pkg::sel_t                  sel_i,
  input  globefish_pkg::adr_t                  adr_i,
  input  globefish_pkg::dat_t                  wdat_i,
  output logic                                 ack_o,
  output globefish_pkg::dat_t                  rdat_o,
  input  logic [globefish_pkg::GPIO_WIDTH-1:0] gpi_i,
  output logic [globefish_pkg::GPIO_WIDTH-1:0] gpo_o,
  output logic [globefish_pkg::GPIO_WIDTH-1:0] gpoe_o
);

  logic       access;
  logic       wr_byte0;
  logic [1:0] ofs;

  assign access   = cyc_i & stb_i & ~ack_o;
  assign wr_byte0 = access & we_i & sel_i[0];
  assign ofs      = adr_i[3:2];

  always_ff @(posedge clk_i or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      ack_o  <= 1'b0;
      gpo_o  <= '0;
      gpoe_o <= '0;
    end else begin
      ack_o <= access;
      // gpi is read-only
      if (wr_byte0 && ofs == globefish_pkg::CSR_GPO_OFS) begin
        gpo_o <= wdat_i[globefish_pkg::GPIO_WIDTH-1:0];
      end
      if (wr_byte0 && ofs == globefish_pkg::CSR_GPOE_OFS) begin
        gpoe_o <= wdat_i[globefish_pkg::GPIO_WIDTH-1:0];
      end
    end
  end

  // readback, zero extended
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (ofs)
        globefish_pkg::CSR_GPO_OFS:  rdat_o <= globefish_pkg::dat_t'(gpo_o);
        globefish_pkg::CSR_GPOE_OFS: rdat_o <= globefish_pkg::dat_t'(gpoe_o);
        globefish_pkg::CSR_GPI_OFS:  rdat_o <= globefish_pkg::dat_t'(gpi_i);
        default:                     rdat_o <= '0;
      endcase
    end
  end

endmodule

//--- logic/globefish_soc.sv
module globefish_soc (
  input  logic                                                 clk_i,
  input  logic                                                 rst_sync_n,
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_en_i,
  // instruction ports
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_imem_stb_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_imem_cyc_i,
  input  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] core_imem_adr_i,
  output logic                [globefish_pkg::NUM_CORES-1:0] core_imem_ack_o,
  output globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_imem_rdat_o,
  // data ports
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_cyc_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_stb_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_we_i,
  input  globefish_pkg::sel_t [globefish_pkg::NUM_CORES-1:0] core_dmem_be_i,
  input  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] core_dmem_adr_i,
  input  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_dmem_wdat_i,
  output logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_ack_o,
  output globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_dmem_rdat_o,
  // run control
  output logic                [globefish_pkg::NUM_CORES-1:0] core_clk_en_o,
  output logic                                               core_rst_n_o,
  // gpio
  input  logic            [globefish_pkg::GPIO_WIDTH-1:0]    gpi_i,
  output logic            [globefish_pkg::GPIO_WIDTH-1:0]    gpo_o,
  output logic            [globefish_pkg::GPIO_WIDTH-1:0]    gpoe_o
);

  // merged masters
  logic                [globefish_pkg::NUM_CORES-1:0] m_cyc;
  logic                [globefish_pkg::NUM_CORES-1:0] m_stb;
  logic                [globefish_pkg::NUM_CORES-1:0] m_we;
  logic                [globefish_pkg::NUM_CORES-1:0] m_ack;
  globefish_pkg::sel_t [globefish_pkg::NUM_CORES-1:0] m_sel;
  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] m_adr;
  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] m_wdat;
  globefish_pkg::dat_t                                m_rdat;
  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_rdat;

  // slave bus
  logic                s_cyc;
  logic                s_we;
  globefish_pkg::sel_t s_sel;
  globefish_pkg::adr_t s_adr;
  globefish_pkg::dat_t s_wdat;
  logic                ram_stb;
  logic                ram_ack;
  globefish_pkg::dat_t ram_rdat;
  logic                csr_stb;
  logic                csr_ack;
  globefish_pkg::dat_t csr_rdat;

  // ######################################
  // core slots

  for (genvar c = 0; c < globefish_pkg::NUM_CORES; c++) begin : g_core
    core_port core_port_inst (
      .clk_i       ( clk_i               ),
      .rst_sync_n  ( rst_sync_n          ),
      .imem_cyc_i  ( core_imem_cyc_i[c]  ),
      .imem_stb_i  ( core_imem_stb_i[c]  ),
      .imem_adr_i  ( core_imem_adr_i[c]  ),
      .imem_ack_o  ( core_imem_ack_o[c]  ),
      .dmem_cyc_i  ( core_dmem_cyc_i[c]  ),
      .dmem_stb_i  ( core_dmem_stb_i[c]  ),
      .dmem_we_i   ( core_dmem_we_i[c]   ),
      .dmem_be_i   ( core_dmem_be_i[c]   ),
      .dmem_adr_i  ( core_dmem_adr_i[c]  ),
      .dmem_wdat_i ( core_dmem_wdat_i[c] ),
      .dmem_ack_o  ( core_dmem_ack_o[c]  ),
      .rdat_o      ( core_rdat[c]        ),
      .cyc_o       ( m_cyc[c]            ),
      .stb_o       ( m_stb[c]            ),
      .we_o        ( m_we[c]             ),
      .sel_o       ( m_sel[c]            ),
      .adr_o       ( m_adr[c]            ),
      .wdat_o      ( m_wdat[c]           ),
      .ack_i       ( m_ack[c]            ),
      .rdat_i      ( m_rdat              )
    );

    // read data fans out to both ports
    assign core_imem_rdat_o[c] = core_rdat[c];
    assign core_dmem_rdat_o[c] = core_rdat[c];
  end

  core_run_ctrl core_run_ctrl_inst (
    .clk_i         ( clk_i         ),
    .rst_sync_n    ( rst_sync_n    ),
    .core_en_i     ( core_en_i     ),
    .core_stb_i    ( m_stb         ),
    .core_clk_en_o ( core_clk_en_o ),
    .core_rst_n_o  ( core_rst_n_o  )
  );

  // ######################################
  // interconnect and slaves

  wb_intercon wb_intercon_inst (
    .clk_i        ( clk_i      ),
    .rst_sync_n   ( rst_sync_n ),
    .m_cyc_i      ( m_cyc      ),
    .m_stb_i      ( m_stb      ),
    .m_we_i       ( m_we       ),
    .m_sel_i      ( m_sel      ),
    .m_adr_i      ( m_adr      ),
    .m_wdat_i     ( m_wdat     ),
    .m_ack_o      ( m_ack      ),
    .m_rdat_o     ( m_rdat     ),
    .s_cyc_o      ( s_cyc      ),
    .s_we_o       ( s_we       ),
    .s_sel_o      ( s_sel      ),
    .s_adr_o      ( s_adr      ),
    .s_wdat_o     ( s_wdat     ),
    .s_ram_stb_o  ( ram_stb    ),
    .s_ram_ack_i  ( ram_ack    ),
    .s_ram_rdat_i ( ram_rdat   ),
    .s_csr_stb_o  ( csr_stb    ),
    .s_csr_ack_i  ( csr_ack    ),
    .s_csr_rdat_i ( csr_rdat   )
  );

  wb_ram wb_ram_inst (
    .clk_i      ( clk_i      ),
    .rst_sync_n ( rst_sync_n ),
    .cyc_i      ( s_cyc      ),
    .stb_i      ( ram_stb    ),
    .we_i       ( s_we       ),
    .sel_i      ( s_sel      ),
    .adr_i      ( s_adr      ),
    .wdat_i     ( s_wdat     ),
    .ack_o      ( ram_ack    ),
    .rdat_o     ( ram_rdat   )
  );

  csr_gpio csr_gpio_inst (
    .clk_i      ( clk_i      ),
    .rst_sync_n ( rst_sync_n ),
    .cyc_i      ( s_cyc      ),
    .stb_i      ( csr_stb    ),
    .we_i       ( s_we       ),
    .sel_i      ( s_sel      ),
    .adr_i      ( s_adr      ),
    .wdat_i     ( s_wdat     ),
    .ack_o      ( csr_ack    ),
    .rdat_o     ( csr_rdat   ),
    .gpi_i      ( gpi_i      ),
    .gpo_o      ( gpo_o      ),
    .gpoe_o     ( gpoe_o     )
  );

endmodule

//--- testbench/soc_checker.sv
module soc_checker (
  input  logic                                                 clk_i,
  input  logic                                                 rst_sync_n,
  input  logic                [globefish_pkg::NUM_CORES-1:0] imem_ack_i,
  input  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] imem_adr_i,
  input  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] imem_rdat_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] dmem_ack_i,
  input  logic                [globefish_pkg::NUM_CORES-1:0] dmem_we_i,
  input  globefish_pkg::sel_t [globefish_pkg::NUM_CORES-1:0] dmem_be_i,
  input  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] dmem_adr_i,
  input  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] dmem_wdat_i,
  input  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] dmem_rdat_i,
  input  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpi_i,
  input  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpo_i,
  input  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpoe_i,
  output int                                                  pass_cnt_o,
  output int                                                  fail_cnt_o,
  output int                                                  ack_cnt_o
);

  globefish_pkg::dat_t                    shadow_ram [globefish_pkg::RAM_DEPTH];
  logic [globefish_pkg::GPIO_WIDTH-1:0]   shadow_gpo = '0;
  logic [globefish_pkg::GPIO_WIDTH-1:0]   shadow_gpoe = '0;
  int                                     pass_cnt = 0;
  int                                     fail_cnt = 0;
  int                                     ack_cnt = 0;

  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;
  assign ack_cnt_o  = ack_cnt;

  // ######################################
  // reference model

  function automatic globefish_pkg::dat_t expected_rdat(globefish_pkg::adr_t adr);
    globefish_pkg::dat_t res;
    res = '0;
    if (adr[31:28] == globefish_pkg::RAM_REGION) begin
      res = shadow_ram[globefish_pkg::ram_idx_t'(adr >> 2)];
    end else if (adr[31:28] == globefish_pkg::CSR_REGION) begin
      case (adr[3:2])
        globefish_pkg::CSR_GPO_OFS:  res = globefish_pkg::dat_t'(shadow_gpo);
        globefish_pkg::CSR_GPOE_OFS: res = globefish_pkg::dat_t'(shadow_gpoe);
        globefish_pkg::CSR_GPI_OFS:  res = globefish_pkg::dat_t'(gpi_i);
        default:                     res = '0;
      endcase
    end
    return res;
  endfunction

  task automatic apply_write(globefish_pkg::adr_t adr, globefish_pkg::sel_t be,
                             globefish_pkg::dat_t wdat);
    globefish_pkg::dat_t     mask;
    globefish_pkg::ram_idx_t idx;
    mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    idx  = globefish_pkg::ram_idx_t'(adr >> 2);
    if (adr[31:28] == globefish_pkg::RAM_REGION) begin
      shadow_ram[idx] = (shadow_ram[idx] & ~mask) | (wdat & mask);
    end else if (adr[31:28] == globefish_pkg::CSR_REGION && be[0]) begin
      // only byte 0 reaches the gpio registers
      if (adr[3:2] == globefish_pkg::CSR_GPO_OFS) begin
        shadow_gpo = wdat[globefish_pkg::GPIO_WIDTH-1:0];
      end
      if (adr[3:2] == globefish_pkg::CSR_GPOE_OFS) begin
        shadow_gpoe = wdat[globefish_pkg::GPIO_WIDTH-1:0];
      end
    end
  endtask

  task automatic compare(string name, globefish_pkg::dat_t exp, globefish_pkg::dat_t act);
    if (exp === act) begin
      pass_cnt++;
    end else begin
      fail_cnt++;
      $display("FAIL %0t %s expected %08h got %08h", $time, name, exp, act);
    end
  endtask

  // ######################################
  // monitor, sampled mid-cycle

  always @(negedge clk_i) begin
    globefish_pkg::core_idx_t c;
    if (rst_sync_n) begin
      for (int i = 0; i < globefish_pkg::NUM_CORES; i++) begin
        c = globefish_pkg::core_idx_t'(i);
        if (imem_ack_i[c]) begin
          ack_cnt++;
          compare($sformatf("core_imem_rdat_o[%0d]", i), expected_rdat(imem_adr_i[c]),
                  imem_rdat_i[c]);
        end
        if (dmem_ack_i[c]) begin
          ack_cnt++;
          if (dmem_we_i[c]) begin
            apply_write(dmem_adr_i[c], dmem_be_i[c], dmem_wdat_i[c]);
          end else begin
            compare($sformatf("core_dmem_rdat_o[%0d]", i), expected_rdat(dmem_adr_i[c]),
                    dmem_rdat_i[c]);
          end
        end
      end
      // pins follow the registers right away
      compare("gpo_o", globefish_pkg::dat_t'(shadow_gpo), globefish_pkg::dat_t'(gpo_i));
      compare("gpoe_o", globefish_pkg::dat_t'(shadow_gpoe), globefish_pkg::dat_t'(gpoe_i));
    end
  end

endmodule

//--- testbench/tb_globefish_soc.sv
module tb_globefish_soc;

  localparam int ACK_TIMEOUT = 100;

  logic                                               clk_i;
  logic                                               rst_sync_n;
  logic                [globefish_pkg::NUM_CORES-1:0] core_en_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_imem_stb_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_imem_cyc_i;
  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] core_imem_adr_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_imem_ack_o;
  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_imem_rdat_o;
  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_cyc_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_stb_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_we_i;
  globefish_pkg::sel_t [globefish_pkg::NUM_CORES-1:0] core_dmem_be_i;
  globefish_pkg::adr_t [globefish_pkg::NUM_CORES-1:0] core_dmem_adr_i;
  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_dmem_wdat_i;
  logic                [globefish_pkg::NUM_CORES-1:0] core_dmem_ack_o;
  globefish_pkg::dat_t [globefish_pkg::NUM_CORES-1:0] core_dmem_rdat_o;
  logic                [globefish_pkg::NUM_CORES-1:0] core_clk_en_o;
  logic                                               core_rst_n_o;
  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpi_i;
  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpo_o;
  logic                [globefish_pkg::GPIO_WIDTH-1:0] gpoe_o;

  int chk_pass;
  int chk_fail;
  int ack_cnt;
  int pass_cnt = 0;
  int err_cnt = 0;
  int fails_seen = 0;

  globefish_soc globefish_soc_inst (.*);

  soc_checker soc_checker_inst (
    .clk_i       ( clk_i            ),
    .rst_sync_n  ( rst_sync_n       ),
    .imem_ack_i  ( core_imem_ack_o  ),
    .imem_adr_i  ( core_imem_adr_i  ),
    .imem_rdat_i ( core_imem_rdat_o ),
    .dmem_ack_i  ( core_dmem_ack_o  ),
    .dmem_we_i   ( core_dmem_we_i   ),
    .dmem_be_i   ( core_dmem_be_i   ),
    .dmem_adr_i  ( core_dmem_adr_i  ),
    .dmem_wdat_i ( core_dmem_wdat_i ),
    .dmem_rdat_i ( core_dmem_rdat_o ),
    .gpi_i       ( gpi_i            ),
    .gpo_i       ( gpo_o            ),
    .gpoe_i      ( gpoe_o           ),
    .pass_cnt_o  ( chk_pass         ),
    .fail_cnt_o  ( chk_fail         ),
    .ack_cnt_o   ( ack_cnt          )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ######################################
  // helpers

  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  function automatic int total_fails();
    return err_cnt + chk_fail;
  endfunction

  function automatic globefish_pkg::adr_t csr_adr(logic [1:0] ofs);
    return {globefish_pkg::CSR_REGION, 24'h0, ofs, 2'b00};
  endfunction

  task automatic check_val(string name, globefish_pkg::dat_t exp, globefish_pkg::dat_t act);
    if (exp === act) begin
      pass_cnt++;
    end else begin
      err_cnt++;
      $display("FAIL %0t %s expected %08h got %08h", $time, name, exp, act);
    end
  endtask

  task automatic abort_run(string why);
    $display("timeout: %s", why);
    $display("TEST FAIL");
    $finish;
  endtask

  task automatic end_test(string name);
    int errs;
    errs       = total_fails() - fails_seen;
    fails_seen = total_fails();
    $display("%s: done, %0d errors", name, errs);
  endtask

  // one classic access, called and left one unit after a rising edge
  task automatic bus_access(globefish_pkg::core_idx_t c, bit instr, globefish_pkg::adr_t adr,
                            bit we, globefish_pkg::sel_t be, globefish_pkg::dat_t wdat);
    int   waited;
    logic got_ack;
    waited  = 0;
    got_ack = 1'b0;
    if (instr) begin
      core_imem_adr_i[c] = adr;
      core_imem_cyc_i[c] = 1'b1;
      core_imem_stb_i[c] = 1'b1;
    end else begin
      core_dmem_adr_i[c]  = adr;
      core_dmem_we_i[c]   = we;
      core_dmem_be_i[c]   = be;
      core_dmem_wdat_i[c] = wdat;
      core_dmem_cyc_i[c]  = 1'b1;
      core_dmem_stb_i[c]  = 1'b1;
    end
    while (!got_ack && waited < ACK_TIMEOUT) begin
      step();
      waited++;
      got_ack = instr ? core_imem_ack_o[c] : core_dmem_ack_o[c];
    end
    if (!got_ack) begin
      abort_run($sformatf("core %0d got no ack for address %08h", c, adr));
    end
    step();
    core_imem_cyc_i[c] = 1'b0;
    core_imem_stb_i[c] = 1'b0;
    core_dmem_cyc_i[c] = 1'b0;
    core_dmem_stb_i[c] = 1'b0;
    core_dmem_we_i[c]  = 1'b0;
    // idle cycle lets the arbiter move on
    step();
  endtask

  // each core stays in its own 4 word window
  task automatic random_traffic(globefish_pkg::core_idx_t c);
    globefish_pkg::adr_t base;
    globefish_pkg::adr_t adr;
    logic [31:0]         r;
    base = {globefish_pkg::RAM_REGION, 28'h0} | (globefish_pkg::adr_t'(c) << 6);
    for (int i = 0; i < 4; i++) begin
      bus_access(c, 1'b0, base + globefish_pkg::adr_t'(i * 4), 1'b1, 4'hF, $urandom());
    end
    for (int i = 0; i < 8; i++) begin
      r   = $urandom();
      adr = base + {28'h0, r[1:0], 2'b00};
      if (r[2]) begin
        bus_access(c, 1'b0, adr, 1'b1, r[7:4], $urandom());
      end else begin
        bus_access(c, r[3], adr, 1'b0, 4'hF, '0);
      end
    end
  endtask

  // ######################################
  // stimulus

  initial begin
    logic [31:0] r;
    int          waited;
    int          acks_before;
    void'($urandom(32'h8d76b6b5));
    rst_sync_n       = 1'b0;
    core_en_i        = '1;
    core_imem_stb_i  = '0;
    core_imem_cyc_i  = '0;
    core_imem_adr_i  = '0;
    core_dmem_cyc_i  = '0;
    core_dmem_stb_i  = '0;
    core_dmem_we_i   = '0;
    core_dmem_be_i   = '0;
    core_dmem_adr_i  = '0;
    core_dmem_wdat_i = '0;
    gpi_i            = '0;
    repeat (4) @(posedge clk_i);
    #1;
    rst_sync_n = 1'b1;

    // test 1, state right after reset and core reset delay
    check_val("core_clk_en_o", globefish_pkg::dat_t'({globefish_pkg::NUM_CORES{1'b1}}),
              globefish_pkg::dat_t'(core_clk_en_o));
    check_val("gpo_o", '0, globefish_pkg::dat_t'(gpo_o));
    check_val("gpoe_o", '0, globefish_pkg::dat_t'(gpoe_o));
    waited = 0;
    while (!core_rst_n_o && waited < ACK_TIMEOUT) begin
      step();
      waited++;
      check_val("core acks", '0, globefish_pkg::dat_t'({core_imem_ack_o, core_dmem_ack_o}));
    end
    if (!core_rst_n_o) begin
      abort_run("core_rst_n_o never rose after reset");
    end
    check_val("core_rst_n_o delay", globefish_pkg::CORE_RST_DELAY, waited);
    end_test("test 1 reset");

    // test 2, byte lanes through the data port, read back on both ports
    bus_access(2'd1, 1'b0, 32'h2000_0100, 1'b1, 4'hF, 32'h1122_3344);
    bus_access(2'd1, 1'b0, 32'h2000_0100, 1'b1, 4'b0101, 32'hAABB_CCDD);
    bus_access(2'd1, 1'b0, 32'h2000_0100, 1'b0, 4'hF, '0);
    bus_access(2'd1, 1'b1, 32'h2000_0100, 1'b0, 4'hF, '0);
    bus_access(2'd1, 1'b0, 32'h2000_0104, 1'b1, 4'hF, 32'h0);
    bus_access(2'd1, 1'b0, 32'h2000_0104, 1'b1, 4'b1100, 32'h5566_7788);
    bus_access(2'd1, 1'b1, 32'h2000_0104, 1'b0, 4'hF, '0);
    end_test("test 2 byte enables");

    // test 3, gpio registers and unmapped space
    r     = $urandom();
    gpi_i = r[globefish_pkg::GPIO_WIDTH-1:0];
    bus_access(2'd2, 1'b0, csr_adr(globefish_pkg::CSR_GPO_OFS), 1'b1, 4'h1, 32'h0000_00A5);
    bus_access(2'd2, 1'b0, csr_adr(globefish_pkg::CSR_GPOE_OFS), 1'b1, 4'hF, 32'h1234_563C);
    check_val("gpo_o", 32'hA5, globefish_pkg::dat_t'(gpo_o));
    check_val("gpoe_o", 32'h3C, globefish_pkg::dat_t'(gpoe_o));
    bus_access(2'd2, 1'b0, csr_adr(globefish_pkg::CSR_GPO_OFS), 1'b0, 4'hF, '0);
    bus_access(2'd2, 1'b0, csr_adr(globefish_pkg::CSR_GPOE_OFS), 1'b0, 4'hF, '0);
    bus_access(2'd2, 1'b1, csr_adr(globefish_pkg::CSR_GPI_OFS), 1'b0, 4'hF, '0);
    bus_access(2'd2, 1'b0, csr_adr(2'd3), 1'b0, 4'hF, '0);
    bus_access(2'd2, 1'b0, 32'h1000_0004, 1'b0, 4'hF, '0);
    bus_access(2'd2, 1'b0, 32'h8000_0000, 1'b1, 4'hF, 32'hFFFF_FFFF);
    bus_access(2'd2, 1'b1, 32'hF000_0010, 1'b0, 4'hF, '0);
    end_test("test 3 csr and unmapped");

    // test 4, all cores at once
    acks_before = ack_cnt;
    fork
      random_traffic(2'd0);
      random_traffic(2'd1);
      random_traffic(2'd2);
      random_traffic(2'd3);
    join
    check_val("acks in random traffic", 32'd48, ack_cnt - acks_before);
    end_test("test 4 random traffic");

    // test 5, core 1 holds the bus with cyc only so core 0 has to wait
    core_dmem_cyc_i[1] = 1'b1;
    step();
    step();
    fork
      bus_access(2'd0, 1'b0, 32'h2000_0200, 1'b1, 4'hF, 32'hCAFE_F00D);
      begin
        step();
        core_en_i[0] = 1'b0;
        repeat (4) begin
          step();
          check_val("core_clk_en_o[0]", 32'd1, globefish_pkg::dat_t'(core_clk_en_o[0]));
        end
        core_dmem_cyc_i[1] = 1'b0;
        waited = 0;
        while (core_clk_en_o[0] && waited < ACK_TIMEOUT) begin
          step();
          waited++;
        end
        if (core_clk_en_o[0]) begin
          abort_run("core_clk_en_o[0] never fell after the access");
        end
        check_val("core_dmem_stb_i[0]", '0, globefish_pkg::dat_t'(core_dmem_stb_i[0]));
        core_en_i[0] = 1'b1;
        step();
        check_val("core_clk_en_o[0]", 32'd1, globefish_pkg::dat_t'(core_clk_en_o[0]));
      end
    join
    end_test("test 5 clock enable hold");

    $display("checks passed %0d, failed %0d", pass_cnt + chk_pass, total_fails());
    if (total_fails() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- globefish_soc.f
logic/globefish_pkg.sv
logic/core_port.sv
logic/core_run_ctrl.sv
logic/wb_intercon.sv
logic/wb_ram.sv
logic/csr_gpio.sv
logic/globefish_soc.sv
testbench/soc_checker.sv
testbench/tb_globefish_soc.sv

//--- run_sim.sh
#!/bin/sh
# build and run the globefish_soc testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module tb_globefish_soc -f globefish_soc.f \
  --Mdir obj_dir -o sim_globefish_soc > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/sim_globefish_soc > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides
if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1
